// File: design/noc_pkg.sv
// shared widths, flit layout and vector types for the router input port
// every design file refers to these by scoped name, so nothing here
// depends on any module
package noc_pkg;

  // virtual channels per input port
  localparam int NumVC = 4;
  localparam int VcIdWidth = 2;

  // output directions of the router: local, north, east, south, west
  localparam int NumPorts = 5;
  localparam int DirWidth = 3;

  // flit layout, msb first:
  //   [last flag][lookahead direction][payload]
  localparam int PayloadWidth = 16;
  localparam int FlitWidth = 1 + DirWidth + PayloadWidth;

  // field positions inside a flit
  localparam int LastBit = FlitWidth - 1;
  localparam int DirMsb = FlitWidth - 2;
  localparam int DirLsb = PayloadWidth;

  // per-vc buffering
  localparam int FifoDepth = 4;
  localparam int FifoPtrWidth = 2;

  // one flit as it travels through the port
  typedef logic [FlitWidth-1:0] flit_t;

  // binary vc index
  typedef logic [VcIdWidth-1:0] vc_id_t;

  // one bit per virtual channel, used for requests, grants and levels
  typedef logic [NumVC-1:0] vc_mask_t;

  // binary direction index as carried in the lookahead field
  // values 5 to 7 are never produced by a legal sender
  typedef logic [DirWidth-1:0] dir_t;

  // one bit per output direction
  typedef logic [NumPorts-1:0] port_mask_t;

endpackage

// File: design/rr_arbiter.sv
// round-robin arbiter over the virtual channels of one input port
// grants the first requester at or after the priority pointer, with wrap
// pointer moves past the granted channel only on an update strobe
`timescale 1ns/100ps

module rr_arbiter (
  input  logic             clk_i,
  input  logic             reset_i,
  input  noc_pkg::vc_mask_t req_i,
  input  logic             update_i,
  output noc_pkg::vc_mask_t grant_oh_o,
  output noc_pkg::vc_id_t   grant_id_o
);

  // priority pointer marks the channel searched first
  noc_pkg::vc_id_t ptr_q;
  noc_pkg::vc_id_t ptr_next;
  logic            any_req;

  assign any_req = |req_i;

  // search upward from the pointer, wrapping at NumVC
  always_comb begin
    int   idx;
    logic hit;
    grant_oh_o = '0;
    grant_id_o = '0;
    hit        = 1'b0;
    idx        = 0;
    for (int off = 0; off < noc_pkg::NumVC; off++) begin
      idx = (int'(ptr_q) + off) % noc_pkg::NumVC;
      // first match wins and later requesters are ignored
      if (!hit && req_i[idx]) begin
        hit             = 1'b1;
        grant_id_o      = noc_pkg::vc_id_t'(idx);
        grant_oh_o[idx] = 1'b1;
      end
    end
  end

  // channel right after the current grant
  assign ptr_next = noc_pkg::vc_id_t'((int'(grant_id_o) + 1) % noc_pkg::NumVC);

  // pointer register
  // starts at vc 0 and holds unless a grant was actually used
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_q <= '0;
    end else if (update_i && any_req) begin
      ptr_q <= ptr_next;
    end
  end

endmodule

// File: design/vc_fifo.sv
// four-entry flit buffer for one virtual channel
// head flit is visible combinationally while the buffer is not empty
// push and pop in the same cycle are both taken even when full
`timescale 1ns/100ps

module vc_fifo (
  input  logic           clk_i,
  input  logic           reset_i,
  input  logic           push_i,
  input  noc_pkg::flit_t data_i,
  input  logic           pop_i,
  output noc_pkg::flit_t head_o,
  output logic           not_empty_o,
  output logic           not_full_o
);

  // flit storage
  // only entries below the count hold live flits
  noc_pkg::flit_t mem_q [noc_pkg::FifoDepth];

  // circular pointers
  // depth is a power of two so they wrap by overflow
  logic [noc_pkg::FifoPtrWidth-1:0] rd_ptr_q;
  logic [noc_pkg::FifoPtrWidth-1:0] wr_ptr_q;

  // one extra bit so a full buffer can be told apart from an empty one
  logic [noc_pkg::FifoPtrWidth:0] count_q;

  logic do_pop;
  logic do_push;

  assign not_empty_o = (count_q != '0);
  assign not_full_o  = (count_q != (noc_pkg::FifoPtrWidth+1)'(noc_pkg::FifoDepth));

  // a pop on an empty buffer does nothing
  assign do_pop = pop_i && not_empty_o;

  // a pop in the same cycle frees the slot for the push
  assign do_push = push_i && (not_full_o || do_pop);

  assign head_o = mem_q[rd_ptr_q];

  // payload store
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // count only changes when exactly one side moves
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// File: design/sa_local.sv
// local switch allocation for one input port
// picks one valid vc head by round robin, presents that head and
// decodes its lookahead field into a one-hot output direction
// the arbiter only rotates after the tail flit of a packet is sent
`timescale 1ns/100ps

module sa_local (
  input  noc_pkg::vc_mask_t              head_valid_i,
  input  noc_pkg::flit_t [noc_pkg::NumVC-1:0] heads_i,
  input  logic                           update_i,
  input  logic                           clk_i,
  input  logic                           reset_i,
  output noc_pkg::vc_id_t                vc_id_o,
  output noc_pkg::vc_mask_t              vc_oh_o,
  output noc_pkg::flit_t                 sel_head_o,
  output noc_pkg::port_mask_t            dir_oh_o
);

  // update strobe as seen by the arbiter
  logic update_arb;

  // some vc holds a flit, so a grant exists
  logic any_valid;

  // lookahead field of the granted head
  noc_pkg::dir_t sel_dir;

  assign any_valid = |head_valid_i;

  // wormhole priority
  // keep the pointer until the tail flit leaves
  assign update_arb = update_i && sel_head_o[noc_pkg::LastBit];

  rr_arbiter u_rr_arbiter (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .req_i      (head_valid_i),
    .update_i   (update_arb),
    .grant_oh_o (vc_oh_o),
    .grant_id_o (vc_id_o)
  );

  // head select is a plain indexed pick on the binary grant
  assign sel_head_o = heads_i[vc_id_o];

  assign sel_dir = sel_head_o[noc_pkg::DirMsb:noc_pkg::DirLsb];

  // one-hot direction
  // compare per port so an illegal code 5..7 simply sets no bit
  always_comb begin
    dir_oh_o = '0;
    for (int p = 0; p < noc_pkg::NumPorts; p++) begin
      if (sel_dir == noc_pkg::dir_t'(p)) begin
        dir_oh_o[p] = any_valid;
      end
    end
  end

endmodule

// File: design/vc_input_port.sv
// one input port of a virtual-channel wormhole router
// flits are buffered per vc, one head is chosen by local allocation and
// offered downstream with its one-hot output direction
// a flit leaves on the edge where its direction bit of out_ready_i is high
`timescale 1ns/100ps

module vc_input_port (
  input  logic                clk_i,
  input  logic                reset_i,
  // upstream link
  input  logic                in_valid_i,
  input  noc_pkg::vc_id_t     in_vc_i,
  input  noc_pkg::flit_t      in_flit_i,
  output noc_pkg::vc_mask_t   in_ready_o,
  // towards the switch
  output logic                out_valid_o,
  output noc_pkg::vc_id_t     out_vc_o,
  output noc_pkg::flit_t      out_flit_o,
  output noc_pkg::port_mask_t out_dir_oh_o,
  input  noc_pkg::port_mask_t out_ready_i
);

  // per-vc strobes and levels
  noc_pkg::vc_mask_t push;
  noc_pkg::vc_mask_t pop;
  noc_pkg::vc_mask_t head_valid;

  // head flit of every vc buffer
  noc_pkg::flit_t [noc_pkg::NumVC-1:0] heads;

  // allocation result
  noc_pkg::vc_id_t     grant_id;
  noc_pkg::vc_mask_t   grant_oh;
  noc_pkg::flit_t      sel_head;
  noc_pkg::port_mask_t dir_oh;

  // the chosen flit is taken this cycle
  logic send;

  // write decode
  // a full vc without a pop drops the flit inside the buffer
  always_comb begin
    push = '0;
    for (int v = 0; v < noc_pkg::NumVC; v++) begin
      push[v] = in_valid_i && (in_vc_i == noc_pkg::vc_id_t'(v));
    end
  end

  for (genvar v = 0; v < noc_pkg::NumVC; v++) begin : g_vc
    vc_fifo u_vc_fifo (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .push_i      (push[v]),
      .data_i      (in_flit_i),
      .pop_i       (pop[v]),
      .head_o      (heads[v]),
      .not_empty_o (head_valid[v]),
      .not_full_o  (in_ready_o[v])
    );
  end

  sa_local u_sa_local (
    .head_valid_i (head_valid),
    .heads_i      (heads),
    .update_i     (send),
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .vc_id_o      (grant_id),
    .vc_oh_o      (grant_oh),
    .sel_head_o   (sel_head),
    .dir_oh_o     (dir_oh)
  );

  // direction mask is zero when nothing is valid, so send needs no extra gating
  // ready on some other direction never releases the flit
  assign send = |(dir_oh & out_ready_i);

  // pop goes only to the granted buffer
  assign pop = grant_oh & {noc_pkg::NumVC{send}};

  assign out_valid_o  = |head_valid;
  assign out_vc_o     = grant_id;
  assign out_flit_o   = sel_head;
  assign out_dir_oh_o = dir_oh;

endmodule

// File: bench/port_checker.sv
// reference model and scoreboard for the vc input port
// mirrors the per-vc buffers and the round-robin pointer, compares the
// dut outputs on every falling edge and counts checks, errors and sent flits
`timescale 1ns/100ps

module port_checker (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                in_valid_i,
  input  noc_pkg::vc_id_t     in_vc_i,
  input  noc_pkg::flit_t      in_flit_i,
  input  noc_pkg::vc_mask_t   in_ready_i,
  input  logic                out_valid_i,
  input  noc_pkg::vc_id_t     out_vc_i,
  input  noc_pkg::flit_t      out_flit_i,
  input  noc_pkg::port_mask_t out_dir_oh_i,
  input  noc_pkg::port_mask_t out_ready_i,
  output int                  err_cnt_o,
  output int                  chk_cnt_o,
  output int                  sent_cnt_o
);

  // model storage with one circular buffer per vc
  noc_pkg::flit_t mem [noc_pkg::NumVC][noc_pkg::FifoDepth];
  int cnt [noc_pkg::NumVC];
  int rd [noc_pkg::NumVC];
  int ptr = 0;

  int err_cnt = 0;
  int chk_cnt = 0;
  int sent_cnt = 0;

  assign err_cnt_o  = err_cnt;
  assign chk_cnt_o  = chk_cnt;
  assign sent_cnt_o = sent_cnt;

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    chk_cnt++;
    if (exp !== act) begin
      $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  // inputs change on the rising edge and are settled by the falling edge
  // the model is then moved to the state after the next rising edge
  always @(negedge clk_i) begin
    int                  grant;
    int                  v;
    int                  dir;
    logic                exp_valid;
    logic                send;
    noc_pkg::flit_t      head;
    noc_pkg::port_mask_t exp_dir;
    noc_pkg::vc_mask_t   exp_ready;
    if (reset_i) begin
      for (int i = 0; i < noc_pkg::NumVC; i++) begin
        cnt[i] = 0;
        rd[i]  = 0;
      end
      ptr = 0;
    end else begin
      // first non-empty vc counting up from the pointer
      grant = -1;
      for (int off = 0; off < noc_pkg::NumVC; off++) begin
        v = (ptr + off) % noc_pkg::NumVC;
        if (grant < 0 && cnt[v] > 0) begin
          grant = v;
        end
      end
      for (int i = 0; i < noc_pkg::NumVC; i++) begin
        exp_ready[i] = (cnt[i] < noc_pkg::FifoDepth);
      end
      exp_valid = (grant >= 0);
      head      = '0;
      exp_dir   = '0;
      if (exp_valid) begin
        head = mem[grant][rd[grant]];
        dir  = int'(head[noc_pkg::DirMsb:noc_pkg::DirLsb]);
        // codes past the last port select nothing
        if (dir < noc_pkg::NumPorts) begin
          exp_dir = noc_pkg::port_mask_t'(1 << dir);
        end
      end
      compare("out_valid_o", 32'(exp_valid), 32'(out_valid_i));
      compare("out_dir_oh_o", 32'(exp_dir), 32'(out_dir_oh_i));
      compare("in_ready_o", 32'(exp_ready), 32'(in_ready_i));
      // vc and flit are don't care while nothing is offered
      if (exp_valid) begin
        compare("out_vc_o", 32'(grant), 32'(out_vc_i));
        compare("out_flit_o", 32'(head), 32'(out_flit_i));
      end
      // pop first since a pop frees the slot for a write in the same cycle
      send = exp_valid && (|(exp_dir & out_ready_i));
      if (send) begin
        rd[grant]  = (rd[grant] + 1) % noc_pkg::FifoDepth;
        cnt[grant] = cnt[grant] - 1;
        sent_cnt++;
        // tail flit releases the priority
        if (head[noc_pkg::LastBit]) begin
          ptr = (grant + 1) % noc_pkg::NumVC;
        end
      end
      if (in_valid_i) begin
        v = int'(in_vc_i);
        if (cnt[v] < noc_pkg::FifoDepth) begin
          mem[v][(rd[v] + cnt[v]) % noc_pkg::FifoDepth] = in_flit_i;
          cnt[v] = cnt[v] + 1;
        end
      end
    end
  end

endmodule

// File: bench/tb_input_port.sv
// testbench for the vc input port
// applies a table of writes and ready masks, drains after every test and
// reports per-test results
// value comparisons are left to the checker module
`timescale 1ns/100ps

module tb_input_port;

  localparam int DrainLimit = 200;
  localparam int NumRandom = 60;

  // one stimulus row
  // pick_vc moves a write to a ready vc
  typedef struct packed {
    logic [3:0]                       test;
    logic                             wr;
    logic                             full;
    logic                             pick_vc;
    noc_pkg::vc_id_t                  vc;
    logic                             last;
    noc_pkg::dir_t                    dir;
    logic [noc_pkg::PayloadWidth-1:0] payload;
    noc_pkg::port_mask_t              ready;
    logic [2:0]                       idle;
  } row_t;

  logic                clk_i;
  logic                reset_i;
  logic                in_valid_i;
  noc_pkg::vc_id_t     in_vc_i;
  noc_pkg::flit_t      in_flit_i;
  noc_pkg::vc_mask_t   in_ready_o;
  logic                out_valid_o;
  noc_pkg::vc_id_t     out_vc_o;
  noc_pkg::flit_t      out_flit_o;
  noc_pkg::port_mask_t out_dir_oh_o;
  noc_pkg::port_mask_t out_ready_i;

  int err_cnt;
  int chk_cnt;
  int sent_cnt;
  int fail_cnt = 0;
  logic [31:0] lfsr_q = 32'h3932;
  row_t table_q [$];

  vc_input_port dut_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .in_valid_i   (in_valid_i),
    .in_vc_i      (in_vc_i),
    .in_flit_i    (in_flit_i),
    .in_ready_o   (in_ready_o),
    .out_valid_o  (out_valid_o),
    .out_vc_o     (out_vc_o),
    .out_flit_o   (out_flit_o),
    .out_dir_oh_o (out_dir_oh_o),
    .out_ready_i  (out_ready_i)
  );

  port_checker u_port_checker (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .in_valid_i   (in_valid_i),
    .in_vc_i      (in_vc_i),
    .in_flit_i    (in_flit_i),
    .in_ready_i   (in_ready_o),
    .out_valid_i  (out_valid_o),
    .out_vc_i     (out_vc_o),
    .out_flit_i   (out_flit_o),
    .out_dir_oh_i (out_dir_oh_o),
    .out_ready_i  (out_ready_i),
    .err_cnt_o    (err_cnt),
    .chk_cnt_o    (chk_cnt),
    .sent_cnt_o   (sent_cnt)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit taken
  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  function automatic noc_pkg::flit_t make_flit(input row_t r);
    noc_pkg::flit_t f;
    f = '0;
    f[noc_pkg::LastBit] = r.last;
    f[noc_pkg::DirMsb:noc_pkg::DirLsb] = r.dir;
    f[noc_pkg::DirLsb-1:0] = r.payload;
    return f;
  endfunction

  function automatic string test_name(input int id);
    case (id)
      1:       return "reset and directions";
      2:       return "round robin";
      3:       return "wormhole priority";
      4:       return "back-pressure";
      5:       return "fifo full";
      6:       return "random traffic";
      default: return "unknown";
    endcase
  endfunction

  task automatic add_row(input int test, input logic wr, input logic full, input logic pick,
                         input int vc, input logic last, input int dir,
                         input logic [noc_pkg::PayloadWidth-1:0] payload,
                         input noc_pkg::port_mask_t ready, input int idle);
    row_t r;
    r.test    = 4'(test);
    r.wr      = wr;
    r.full    = full;
    r.pick_vc = pick;
    r.vc      = noc_pkg::vc_id_t'(vc);
    r.last    = last;
    r.dir     = noc_pkg::dir_t'(dir);
    r.payload = payload;
    r.ready   = ready;
    r.idle    = 3'(idle);
    table_q.push_back(r);
  endtask

  task automatic fill_table();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    // single flits to every direction
    for (int p = 0; p < noc_pkg::NumPorts; p++) begin
      take_bits(16, a);
      add_row(1, 1'b1, 1'b0, 1'b0, 0, 1'b1, p, a[15:0], 5'h1f, 2);
    end
    // two rounds of filling all vcs while blocked and then releasing
    for (int r = 0; r < 2; r++) begin
      for (int v = 0; v < noc_pkg::NumVC; v++) begin
        add_row(2, 1'b1, 1'b0, 1'b0, v, 1'b1, v, 16'(8192 + 16 * r + v), 5'h00, 0);
      end
      add_row(2, 1'b0, 1'b0, 1'b0, 0, 1'b0, 0, 16'h0, 5'h1f, 6);
    end
    // three-flit packet on vc 1 interleaved with a packet on vc 2
    add_row(3, 1'b1, 1'b0, 1'b0, 1, 1'b0, 2, 16'h3100, 5'h00, 0);
    add_row(3, 1'b1, 1'b0, 1'b0, 2, 1'b0, 3, 16'h3200, 5'h00, 0);
    add_row(3, 1'b1, 1'b0, 1'b0, 1, 1'b0, 2, 16'h3101, 5'h00, 0);
    add_row(3, 1'b1, 1'b0, 1'b0, 2, 1'b1, 3, 16'h3201, 5'h00, 0);
    add_row(3, 1'b1, 1'b0, 1'b0, 1, 1'b1, 2, 16'h3102, 5'h00, 0);
    add_row(3, 1'b0, 1'b0, 1'b0, 0, 1'b0, 0, 16'h0, 5'h1f, 8);
    // north held off while every other direction is ready
    add_row(4, 1'b1, 1'b0, 1'b0, 0, 1'b1, 1, 16'h4444, 5'b11101, 5);
    add_row(4, 1'b0, 1'b0, 1'b0, 0, 1'b0, 0, 16'h0, 5'b11101, 3);
    add_row(4, 1'b0, 1'b0, 1'b0, 0, 1'b0, 0, 16'h0, 5'b00010, 2);
    // four writes fill vc 3
    // a write to the full vc is skipped
    // a write together with a send keeps it full
    for (int k = 0; k < noc_pkg::FifoDepth; k++) begin
      add_row(5, 1'b1, 1'b0, 1'b0, 3, 1'b1, 4, 16'(20480 + k), 5'h00,
              (k == noc_pkg::FifoDepth - 1) ? 1 : 0);
    end
    add_row(5, 1'b1, 1'b1, 1'b0, 3, 1'b1, 4, 16'h5fff, 5'h00, 0);
    add_row(5, 1'b1, 1'b0, 1'b0, 3, 1'b1, 4, 16'h5010, 5'b10000, 0);
    add_row(5, 1'b0, 1'b0, 1'b0, 0, 1'b0, 0, 16'h0, 5'h00, 0);
    add_row(5, 1'b1, 1'b1, 1'b0, 3, 1'b1, 4, 16'h5ffe, 5'h00, 0);
    // random rows keep at least one idle cycle so the level seen is up to date
    for (int n = 0; n < NumRandom; n++) begin
      take_bits(2, a);
      take_bits(4, b);
      take_bits(16, c);
      take_bits(6, d);
      add_row(6, 1'b1, 1'b0, 1'b1, int'(a[1:0]), b[3], int'(b[2:0]) % noc_pkg::NumPorts,
              c[15:0], noc_pkg::port_mask_t'(d[5:1]), 1 + int'(d[0]));
    end
  endtask

  task automatic apply_row(input row_t r);
    logic            do_wr;
    logic            found;
    noc_pkg::vc_id_t vc;
    noc_pkg::vc_id_t cand;
    do_wr = r.wr;
    vc    = r.vc;
    found = 1'b0;
    @(negedge clk_i);
    if (r.full) begin
      if (in_ready_o[vc]) begin
        $display("test %0d: vc %0d should be full but in_ready_o is high", r.test, vc);
        fail_cnt++;
      end
      $display("test %0d: write to full vc %0d skipped", r.test, vc);
      do_wr = 1'b0;
    end else if (r.pick_vc && do_wr) begin
      for (int k = 0; k < noc_pkg::NumVC; k++) begin
        cand = noc_pkg::vc_id_t'(int'(r.vc) + k);
        if (!found && in_ready_o[cand]) begin
          found = 1'b1;
          vc    = cand;
        end
      end
      do_wr = found;
    end
    @(posedge clk_i);
    in_valid_i  <= do_wr;
    in_vc_i     <= vc;
    in_flit_i   <= make_flit(r);
    out_ready_i <= r.ready;
    for (int k = 0; k < int'(r.idle); k++) begin
      @(posedge clk_i);
      in_valid_i <= 1'b0;
    end
  endtask

  // open every direction and wait for the port to run empty
  task automatic finish_test(input int id, input int base);
    logic ok;
    int   fails;
    ok = 1'b0;
    @(posedge clk_i);
    in_valid_i  <= 1'b0;
    out_ready_i <= '1;
    for (int cyc = 0; cyc < DrainLimit && !ok; cyc++) begin
      @(negedge clk_i);
      ok = !out_valid_o;
    end
    if (!ok) begin
      $display("test %0d: port did not drain within %0d cycles", id, DrainLimit);
      fail_cnt++;
    end
    fails = err_cnt + fail_cnt - base;
    if (fails == 0) begin
      $display("test %0d %s: ok, %0d flits sent so far", id, test_name(id), sent_cnt);
    end else begin
      $display("test %0d %s: failed with %0d errors", id, test_name(id), fails);
    end
  endtask

  initial begin
    int cur;
    int base;
    in_valid_i  = 1'b0;
    in_vc_i     = '0;
    in_flit_i   = '0;
    out_ready_i = '0;
    reset_i     = 1'b1;
    fill_table();
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;
    cur  = int'(table_q[0].test);
    base = 0;
    for (int i = 0; i < table_q.size(); i++) begin
      if (int'(table_q[i].test) != cur) begin
        finish_test(cur, base);
        cur  = int'(table_q[i].test);
        base = err_cnt + fail_cnt;
      end
      apply_row(table_q[i]);
    end
    finish_test(cur, base);
    $display("checks %0d, mismatches %0d, other failures %0d, flits sent %0d",
             chk_cnt, err_cnt, fail_cnt, sent_cnt);
    if (err_cnt == 0 && fail_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: all.f
design/noc_pkg.sv
design/rr_arbiter.sv
design/vc_fifo.sv
design/sa_local.sv
design/vc_input_port.sv
bench/port_checker.sv
bench/tb_input_port.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the input port testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  -f all.f \
  --top-module tb_input_port \
  -Mdir obj_dir \
  -o sim_input_port

./obj_dir/sim_input_port | tee sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
  echo "simulation reported failure"
  exit 1
fi

if ! grep -q '\*\* PASS \*\*' sim.log; then
  echo "simulation ended without a result"
  exit 1
fi

echo "simulation passed"
